/* hw/fp_exec_cluster.sv */
// ======================================================================
// FP execution cluster top
// ======================================================================
`default_nettype none
`timescale 1ns/1ps

`include "fpu_cfg.svh"

module fp_exec_cluster (
    input  wire logic                       clk_i,
    input  wire logic                       rst_n_i,
    input  wire logic                       flush_i,
    // Issue side
    input  wire logic                       in_valid_i,
    input  wire logic [`FP_CTL_LEN-1:0]     in_ctl_i,
    input  wire logic [`FP_XLEN-1:0]        in_rs1_i,
    input  wire logic [`FP_XLEN-1:0]        in_rs2_i,
    input  wire logic [`FP_IDX_W-1:0]       in_idx_i,
    output      logic                       in_ready_o,
    // Result side
    output      logic                       out_valid_o,
    output      logic [`FP_IDX_W-1:0]       out_idx_o,
    output      logic [`FP_XLEN-1:0]        out_result_o,
    output      logic                       out_except_raised_o,
    output      logic [`FP_EXCEPT_LEN-1:0]  out_except_code_o,
    input  wire logic                       out_ready_i
);

    import fpu_pkg::*;

    // Head entry of the station
    logic                   head_valid;
    logic [`FP_CTL_LEN-1:0] head_ctl;
    logic [`FP_XLEN-1:0]    head_rs1, head_rs2;
    logic [`FP_IDX_W-1:0]   head_idx;
    // Control strobes
    logic                   issue_start, result_load, exec_done, head_free;

    fp_rs_entry_table u_table (
        .clk_i, .rst_n_i, .flush_i,
        .in_valid_i, .in_ctl_i, .in_rs1_i, .in_rs2_i, .in_idx_i, .in_ready_o,
        .head_free_i (head_free),   .head_valid_o (head_valid),
        .head_ctl_o  (head_ctl),    .head_rs1_o   (head_rs1),
        .head_rs2_o  (head_rs2),    .head_idx_o   (head_idx)
    );

    fp_issue_ctrl u_ctrl (
        .clk_i, .rst_n_i, .flush_i,
        .head_valid_i  (head_valid),  .exec_done_i   (exec_done),
        .out_ready_i,                 .issue_start_o (issue_start),
        .result_load_o (result_load), .out_valid_o,
        .head_free_o   (head_free)
    );

    // Latency class taken from the head operation field
    fp_latency_timer u_timer (
        .clk_i, .rst_n_i, .flush_i,
        .start_i (issue_start), .op_i (fp_op_e'(head_ctl[2:0])), .done_o (exec_done)
    );

    fpu_sgnj_minmax u_fpu (
        .clk_i, .rst_n_i, .flush_i,
        .issue_start_i (issue_start), .result_load_i (result_load),
        .ctl_i (head_ctl), .rs1_i (head_rs1), .rs2_i (head_rs2), .idx_i (head_idx),
        .result_o (out_result_o), .idx_o (out_idx_o),
        .except_raised_o (out_except_raised_o), .except_code_o (out_except_code_o)
    );

endmodule

`default_nettype wire

/* hw/fp_issue_ctrl.sv */
// ======================================================================
// FP issue control FSM
// ======================================================================
`default_nettype none
`timescale 1ns/1ps

module fp_issue_ctrl (
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  wire logic flush_i,
    input  wire logic head_valid_i,
    input  wire logic exec_done_i,
    input  wire logic out_ready_i,
    output      logic issue_start_o,
    output      logic result_load_o,
    output      logic out_valid_o,
    output      logic head_free_o
);

    // State encoding
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_ISSUE  = 2'd1;
    localparam logic [1:0] ST_EXEC   = 2'd2;
    localparam logic [1:0] ST_RESULT = 2'd3;

    logic [1:0] state_q;
    logic [1:0] state_d;

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // Oldest entry goes out as soon as it is buffered
                if (head_valid_i) begin
                    state_d = ST_ISSUE;
                end
            end
            ST_ISSUE: begin
                state_d = ST_EXEC;
            end
            ST_EXEC: begin
                if (exec_done_i) begin
                    state_d = ST_RESULT;
                end
            end
            default: begin
                // Result held until the consumer takes it
                if (out_ready_i) begin
                    state_d = ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else if (flush_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Operand latch and timer start, one cycle in ISSUE
    assign issue_start_o = (state_q == ST_ISSUE);
    // Result register load at the end of execution
    assign result_load_o = (state_q == ST_EXEC) && exec_done_i;
    assign out_valid_o   = (state_q == ST_RESULT);
    // Head entry retired on hand-off
    assign head_free_o   = (state_q == ST_RESULT) && out_ready_i;

endmodule

`default_nettype wire

/* hw/fp_latency_timer.sv */
// ======================================================================
// FP execution latency timer
// ======================================================================
`default_nettype none
`timescale 1ns/1ps

`include "fpu_cfg.svh"

module fp_latency_timer (
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            flush_i,
    input  wire logic            start_i,
    input  wire fpu_pkg::fp_op_e op_i,
    output      logic            done_o
);

    import fpu_pkg::*;

    localparam int CNT_W = $clog2(`FP_LAT_MINMAX + 1);

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] load_val;

    // Latency per operation class
    assign load_val = ((op_i == OP_MIN) || (op_i == OP_MAX)) ?
                      CNT_W'(`FP_LAT_MINMAX) : CNT_W'(`FP_LAT_SGNJ);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (flush_i) begin
            cnt_q <= '0;
        end else if (start_i) begin
            cnt_q <= load_val;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - CNT_W'(1);
        end
    end

    // Last execution cycle
    assign done_o = (cnt_q == CNT_W'(1));

endmodule

`default_nettype wire

/* hw/fp_rs_entry_table.sv */
// ======================================================================
// FP reservation station entry table
// ======================================================================
`default_nettype none
`timescale 1ns/1ps

`include "fpu_cfg.svh"

module fp_rs_entry_table (
    input  wire logic                      clk_i,
    input  wire logic                      rst_n_i,
    input  wire logic                      flush_i,
    // Issue side
    input  wire logic                      in_valid_i,
    input  wire logic [`FP_CTL_LEN-1:0]    in_ctl_i,
    input  wire logic [`FP_XLEN-1:0]       in_rs1_i,
    input  wire logic [`FP_XLEN-1:0]       in_rs2_i,
    input  wire logic [`FP_IDX_W-1:0]      in_idx_i,
    output      logic                      in_ready_o,
    // Head entry toward the controller and the FP unit
    input  wire logic                      head_free_i,
    output      logic                      head_valid_o,
    output      logic [`FP_CTL_LEN-1:0]    head_ctl_o,
    output      logic [`FP_XLEN-1:0]       head_rs1_o,
    output      logic [`FP_XLEN-1:0]       head_rs2_o,
    output      logic [`FP_IDX_W-1:0]      head_idx_o
);

    localparam int PTR_W = `FP_IDX_W;
    localparam int CNT_W = `FP_IDX_W + 1;

    // Entry storage
    logic [`FP_CTL_LEN-1:0] ctl_mem [`FP_RS_DEPTH];
    logic [`FP_XLEN-1:0]    rs1_mem [`FP_RS_DEPTH];
    logic [`FP_XLEN-1:0]    rs2_mem [`FP_RS_DEPTH];
    logic [`FP_IDX_W-1:0]   idx_mem [`FP_RS_DEPTH];

    // Pointers and occupancy
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    logic full;
    logic empty;
    logic accept;
    logic release_head;

    assign full  = (count_q == CNT_W'(`FP_RS_DEPTH));
    assign empty = (count_q == '0);

    // Handshake toward the issue stage
    assign in_ready_o = !full;
    assign accept     = in_valid_i && in_ready_o;
    // Only an occupied head can be released
    assign release_head = head_free_i && !empty;

    // Head view
    assign head_valid_o = !empty;
    assign head_ctl_o   = ctl_mem[head_q];
    assign head_rs1_o   = rs1_mem[head_q];
    assign head_rs2_o   = rs2_mem[head_q];
    assign head_idx_o   = idx_mem[head_q];

    // Next slot with wrap at the last entry
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`FP_RS_DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    // Entry write at the tail
    always_ff @(posedge clk_i) begin
        if (accept) begin
            ctl_mem[tail_q] <= in_ctl_i;
            rs1_mem[tail_q] <= in_rs1_i;
            rs2_mem[tail_q] <= in_rs2_i;
            idx_mem[tail_q] <= in_idx_i;
        end
    end

    // Pointer and count update
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // Drop every buffered entry
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (accept) begin
                tail_q <= ptr_inc(tail_q);
            end
            if (release_head) begin
                head_q <= ptr_inc(head_q);
            end
            case ({accept, release_head})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/fpu_cfg.svh */
// ======================================================================
// FP execution cluster configuration
// ======================================================================

`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

// Operand and result width
`define FP_XLEN 64

// Reservation station size and entry index width
`define FP_RS_DEPTH 4
`define FP_IDX_W 2

// Control word and exception code widths
`define FP_CTL_LEN 4
`define FP_EXCEPT_LEN 2

// Execution cycles per operation class
`define FP_LAT_SGNJ 1
`define FP_LAT_MINMAX 2

`endif

/* hw/fpu_pkg.sv */
// ======================================================================
// FP unit types and constants
// ======================================================================
`default_nettype none

`include "fpu_cfg.svh"

package fpu_pkg;

    // Operation field, ctl[2:0]
    // ctl[3] selects the format, 1 for double and 0 for single
    typedef enum logic [2:0] {
        OP_MV    = 3'd0,
        OP_SGNJ  = 3'd1,
        OP_SGNJN = 3'd2,
        OP_SGNJX = 3'd3,
        OP_MIN   = 3'd4,
        OP_MAX   = 3'd5
    } fp_op_e;

    // Operand word, read as a double or as a NaN-boxed single
    typedef union packed {
        struct packed {
            logic        sign;
            logic [10:0] exp;
            logic [51:0] mant;
        } d;
        struct packed {
            logic [31:0] box;
            logic        sign;
            logic [7:0]  exp;
            logic [22:0] mant;
        } s;
    } fp_word_u;

    // Canonical quiet NaNs
    localparam logic [`FP_XLEN-1:0] FP_CNAN_D = 64'h7ff8_0000_0000_0000;
    // Single canonical NaN, already boxed
    localparam logic [`FP_XLEN-1:0] FP_CNAN_S = 64'hffff_ffff_7fc0_0000;

    // Exception codes
    localparam logic [`FP_EXCEPT_LEN-1:0] FP_EXC_NONE    = 2'd0;
    localparam logic [`FP_EXCEPT_LEN-1:0] FP_EXC_INVALID = 2'd2;

endpackage

`default_nettype wire

/* hw/fpu_sgnj_minmax.sv */
// ======================================================================
// FP sign injection, min/max and move unit
// ======================================================================
`default_nettype none
`timescale 1ns/1ps

`include "fpu_cfg.svh"

module fpu_sgnj_minmax (
    input  wire logic                       clk_i,
    input  wire logic                       rst_n_i,
    input  wire logic                       flush_i,
    input  wire logic                       issue_start_i,
    input  wire logic                       result_load_i,
    input  wire logic [`FP_CTL_LEN-1:0]     ctl_i,
    input  wire logic [`FP_XLEN-1:0]        rs1_i,
    input  wire logic [`FP_XLEN-1:0]        rs2_i,
    input  wire logic [`FP_IDX_W-1:0]       idx_i,
    output      logic [`FP_XLEN-1:0]        result_o,
    output      logic [`FP_IDX_W-1:0]       idx_o,
    output      logic                       except_raised_o,
    output      logic [`FP_EXCEPT_LEN-1:0]  except_code_o
);

    import fpu_pkg::*;

    // Latched operation
    fp_word_u               a_q, b_q;
    logic [`FP_CTL_LEN-1:0] ctl_q;
    logic [`FP_IDX_W-1:0]   idx_q;

    fp_word_u a_w, b_w;
    logic     is_dbl, a_nan, b_nan, a_snan, b_snan, a_lt_b, is_minmax, new_sign;
    logic [`FP_XLEN-1:0] cnan, minmax_res, result_d;
    fp_op_e   op;

    function automatic logic w_sign(input fp_word_u w, input logic dbl);
        return dbl ? w.d.sign : w.s.sign;
    endfunction

    // Exponent and mantissa as one unsigned magnitude
    function automatic logic [62:0] w_mag(input fp_word_u w, input logic dbl);
        return dbl ? {w.d.exp, w.d.mant} : {32'b0, w.s.exp, w.s.mant};
    endfunction

    function automatic logic w_nan(input fp_word_u w, input logic dbl);
        return dbl ? ((&w.d.exp) && (|w.d.mant)) : ((&w.s.exp) && (|w.s.mant));
    endfunction

    // Quiet bit clear on a NaN
    function automatic logic w_snan(input fp_word_u w, input logic dbl);
        return w_nan(w, dbl) && !(dbl ? w.d.mant[51] : w.s.mant[22]);
    endfunction

    always_ff @(posedge clk_i) begin
        if (issue_start_i) begin
            a_q <= rs1_i;
            b_q <= rs2_i;
            ctl_q <= ctl_i;
            idx_q <= idx_i;
        end
    end

    assign is_dbl = ctl_q[3];
    assign op     = fp_op_e'(ctl_q[2:0]);
    assign cnan   = is_dbl ? FP_CNAN_D : FP_CNAN_S;

    // A bad single box reads as the canonical NaN
    assign a_w = (!is_dbl && (a_q.s.box != '1)) ? FP_CNAN_S : a_q;
    assign b_w = (!is_dbl && (b_q.s.box != '1)) ? FP_CNAN_S : b_q;

    assign a_nan  = w_nan(a_w, is_dbl);
    assign b_nan  = w_nan(b_w, is_dbl);
    assign a_snan = w_snan(a_w, is_dbl);
    assign b_snan = w_snan(b_w, is_dbl);
    assign is_minmax = (op == OP_MIN) || (op == OP_MAX);

    // Sign and magnitude order with -0 below +0
    always_comb begin
        if (w_sign(a_w, is_dbl) != w_sign(b_w, is_dbl)) a_lt_b = w_sign(a_w, is_dbl);
        else if (w_sign(a_w, is_dbl))  a_lt_b = w_mag(a_w, is_dbl) > w_mag(b_w, is_dbl);
        else                           a_lt_b = w_mag(a_w, is_dbl) < w_mag(b_w, is_dbl);
    end

    // NaN operands give way to the other one
    always_comb begin
        if (a_nan && b_nan) minmax_res = cnan;
        else if (a_nan)     minmax_res = b_w;
        else if (b_nan)     minmax_res = a_w;
        else                minmax_res = ((op == OP_MIN) == a_lt_b) ? a_w : b_w;
    end

    // Sign source for the injection ops
    always_comb begin
        case (op)
            OP_SGNJN: new_sign = !w_sign(b_w, is_dbl);
            OP_SGNJX: new_sign = w_sign(a_w, is_dbl) ^ w_sign(b_w, is_dbl);
            default:  new_sign = w_sign(b_w, is_dbl);
        endcase
    end

    always_comb begin
        case (op)
            OP_SGNJ, OP_SGNJN, OP_SGNJX:
                result_d = is_dbl ? {new_sign, a_w.d.exp, a_w.d.mant}
                                  : {32'hffff_ffff, new_sign, a_w.s.exp, a_w.s.mant};
            OP_MIN, OP_MAX: result_d = minmax_res;
            default:        result_d = a_q;
        endcase
    end

    // Result register held through the output hand-off
    always_ff @(posedge clk_i) begin
        if (result_load_i) begin
            result_o <= result_d;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            except_raised_o <= 1'b0;
            except_code_o   <= FP_EXC_NONE;
        end else if (flush_i) begin
            except_raised_o <= 1'b0;
            except_code_o   <= FP_EXC_NONE;
        end else if (result_load_i) begin
            // Signaling NaN into min/max is invalid
            except_raised_o <= is_minmax && (a_snan || b_snan);
            except_code_o   <= (is_minmax && (a_snan || b_snan)) ? FP_EXC_INVALID : FP_EXC_NONE;
        end
    end

    // Index stays latched until the next issue
    assign idx_o = idx_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile and run the FP execution cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module fp_exec_cluster_tb -f vlog.f -o fp_exec_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/fp_exec_sim)
status=$?
printf '%s\n' "$sim_out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only when the testbench printed its pass line
if printf '%s\n' "$sim_out" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "Simulation reported failures"
exit 1

/* test/fp_exec_cluster_tb.sv */
// ======================================================================
// FP execution cluster testbench
// ======================================================================
`default_nettype none
`timescale 1ns/1ps

`include "fpu_cfg.svh"

module fp_exec_cluster_tb;

    import fpu_pkg::*;

    localparam int WAIT_LIMIT = 50;
    // Min/max control words with the format bit on top
    localparam logic [3:0] D_MIN = {1'b1, OP_MIN};
    localparam logic [3:0] D_MAX = {1'b1, OP_MAX};
    localparam logic [3:0] S_MIN = {1'b0, OP_MIN};
    localparam logic [3:0] S_MAX = {1'b0, OP_MAX};

    logic                      clk_i, rst_n_i, flush_i;
    logic                      in_valid_i, in_ready_o;
    logic [`FP_CTL_LEN-1:0]    in_ctl_i;
    logic [`FP_XLEN-1:0]       in_rs1_i, in_rs2_i;
    logic [`FP_IDX_W-1:0]      in_idx_i;
    logic                      out_valid_o, out_ready_i, out_except_raised_o;
    logic [`FP_IDX_W-1:0]      out_idx_o;
    logic [`FP_XLEN-1:0]       out_result_o;
    logic [`FP_EXCEPT_LEN-1:0] out_except_code_o;

    int          err_count   = 0;
    int          check_count = 0;
    // Level of out_ready_i between hand-offs
    logic        ready_idle  = 1'b1;
    logic [31:0] lfsr_q      = 32'h6fd3_67de;

    fp_exec_cluster dut0 (
        .clk_i, .rst_n_i, .flush_i,
        .in_valid_i, .in_ctl_i, .in_rs1_i, .in_rs2_i, .in_idx_i, .in_ready_o,
        .out_valid_o, .out_idx_o, .out_result_o, .out_except_raised_o,
        .out_except_code_o, .out_ready_i
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int nbits, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[62:0], lfsr_q[0]};
        end
    endtask

    // Random double or properly boxed single
    task automatic random_operand(input logic dbl, output logic [63:0] v);
        logic [63:0] w;
        random_bits(dbl ? 64 : 32, w);
        v = dbl ? w : {32'hffff_ffff, w[31:0]};
    endtask

    // Expected {exception raised, result} from the operation rules
    function automatic logic [64:0] model_op(input logic [3:0] ctl,
                                             input logic [63:0] a, input logic [63:0] b);
        logic        dbl, sx, sy, nx, ny, snx, sny, lt, ns, mm;
        logic [63:0] x, y, cnan, r;
        logic [62:0] mx, my;
        fp_op_e      op;
        dbl = ctl[3];
        op  = fp_op_e'(ctl[2:0]);
        // Singles move to the low half where a bad box reads as canonical NaN
        if (dbl) begin
            x = a;
            y = b;
            cnan = 64'h7ff8_0000_0000_0000;
        end else begin
            x = (a[63:32] == 32'hffff_ffff) ? {32'd0, a[31:0]} : 64'h0000_0000_7fc0_0000;
            y = (b[63:32] == 32'hffff_ffff) ? {32'd0, b[31:0]} : 64'h0000_0000_7fc0_0000;
            cnan = 64'h0000_0000_7fc0_0000;
        end
        sx  = dbl ? x[63] : x[31];
        sy  = dbl ? y[63] : y[31];
        mx  = dbl ? x[62:0] : {32'd0, x[30:0]};
        my  = dbl ? y[62:0] : {32'd0, y[30:0]};
        nx  = dbl ? ((&x[62:52]) && (|x[51:0])) : ((&x[30:23]) && (|x[22:0]));
        ny  = dbl ? ((&y[62:52]) && (|y[51:0])) : ((&y[30:23]) && (|y[22:0]));
        snx = nx && !(dbl ? x[51] : x[22]);
        sny = ny && !(dbl ? y[51] : y[22]);
        mm  = (op == OP_MIN) || (op == OP_MAX);
        // Negative sign orders first and magnitude order flips below zero
        lt  = (sx != sy) ? sx : (sx ? (mx > my) : (mx < my));
        case (op)
            OP_SGNJN: ns = !sy;
            OP_SGNJX: ns = sx ^ sy;
            default:  ns = sy;
        endcase
        if (mm) begin
            if (nx && ny) r = cnan;
            else if (nx)  r = y;
            else if (ny)  r = x;
            else if (op == OP_MIN) r = lt ? x : y;
            else          r = lt ? y : x;
        end else begin
            r = dbl ? {ns, x[62:0]} : {32'd0, ns, x[30:0]};
        end
        if (op == OP_MV) begin
            return {1'b0, a};
        end
        return {mm && (snx || sny), dbl ? r : {32'hffff_ffff, r[31:0]}};
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
        check_count++;
        if (got !== expected) begin
            $display("Error: time %0t, %s: got %h, expected %h", $time, what, got, expected);
            err_count++;
        end
    endtask

    task automatic step_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("Test %s finished with %0d error(s)", name, err_count - errs_before);
    endtask

    // Offer one operation and hold it until the accept edge
    task automatic send_op(input logic [3:0] ctl, input logic [63:0] a,
                           input logic [63:0] b, input logic [1:0] idx);
        int waited;
        waited = 0;
        in_valid_i = 1'b1;
        in_ctl_i   = ctl;
        in_rs1_i   = a;
        in_rs2_i   = b;
        in_idx_i   = idx;
        while (!in_ready_o && waited < WAIT_LIMIT) begin
            step_cycle();
            waited++;
        end
        if (!in_ready_o) begin
            $display("Timeout: the cluster did not accept an operation in %0d cycles",
                     WAIT_LIMIT);
            err_count++;
        end
        step_cycle();
        in_valid_i = 1'b0;
    endtask

    task automatic wait_out_valid(output int cycles);
        cycles = 0;
        while (!out_valid_o && cycles < WAIT_LIMIT) begin
            step_cycle();
            cycles++;
        end
        if (!out_valid_o) begin
            $display("Timeout: no result came out within %0d cycles", WAIT_LIMIT);
            err_count++;
        end
    endtask

    // Check the held result and complete the hand-off
    task automatic receive_result(input logic [1:0] idx, input logic [63:0] res,
                                  input logic raised, input string name);
        int cycles;
        wait_out_valid(cycles);
        check_value(64'(out_idx_o), 64'(idx), {name, " index"});
        check_value(out_result_o, res, {name, " result"});
        check_value(64'(out_except_raised_o), 64'(raised), {name, " exception flag"});
        check_value(64'(out_except_code_o),
                    64'(raised ? FP_EXC_INVALID : FP_EXC_NONE), {name, " exception code"});
        out_ready_i = 1'b1;
        step_cycle();
        out_ready_i = ready_idle;
    endtask

    task automatic run_op(input logic [3:0] ctl, input logic [63:0] a,
                          input logic [63:0] b, input logic [1:0] idx, input string name);
        logic [64:0] m;
        m = model_op(ctl, a, b);
        send_op(ctl, a, b, idx);
        receive_result(idx, m[63:0], m[64], name);
    endtask

    // Hand-written expectation that the model must also reproduce
    task automatic run_case(input logic [3:0] ctl, input logic [63:0] a, input logic [63:0] b,
                            input logic [63:0] res, input logic raised, input string name);
        logic [64:0] m;
        m = model_op(ctl, a, b);
        check_value(m[63:0], res, {name, " model result"});
        check_value(64'(m[64]), 64'(raised), {name, " model flag"});
        send_op(ctl, a, b, 2'd1);
        receive_result(2'd1, res, raised, name);
    endtask

    task automatic reset_state();
        int e0;
        e0 = err_count;
        check_value(64'(out_valid_o), 64'd0, "reset out_valid");
        check_value(64'(out_except_raised_o), 64'd0, "reset exception flag");
        check_value(64'(out_except_code_o), 64'd0, "reset exception code");
        check_value(64'(in_ready_o), 64'd1, "reset in_ready");
        report_test("reset", e0);
    endtask

    task automatic sign_ops_random();
        int          e0;
        logic [63:0] a, b;
        logic [1:0]  idx;
        e0  = err_count;
        idx = 2'd0;
        for (int d = 0; d < 2; d++) begin
            for (int o = 0; o < 6; o++) begin
                for (int n = 0; n < 3; n++) begin
                    random_operand(d[0], a);
                    random_operand(d[0], b);
                    run_op({d[0], o[2:0]}, a, b, idx, $sformatf("op %0d fmt %0d", o, d));
                    idx = idx + 2'd1;
                end
            end
        end
        report_test("sign_ops", e0);
    endtask

    task automatic minmax_special();
        int e0;
        e0 = err_count;
        run_case(D_MIN, 64'h0, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 0, "min zeros");
        run_case(D_MAX, 64'h8000_0000_0000_0000, 64'h0, 64'h0, 0, "max zeros");
        run_case(S_MIN, 64'hffff_ffff_0000_0000, 64'hffff_ffff_8000_0000,
                 64'hffff_ffff_8000_0000, 0, "single min zeros");
        run_case(D_MIN, 64'hbff0_0000_0000_0000, 64'h4000_0000_0000_0000,
                 64'hbff0_0000_0000_0000, 0, "min negative");
        run_case(D_MIN, 64'h7ff8_0000_0000_0001, 64'h3ff0_0000_0000_0000,
                 64'h3ff0_0000_0000_0000, 0, "min quiet NaN");
        run_case(D_MAX, 64'h4000_0000_0000_0000, 64'hfff8_0000_0000_0000,
                 64'h4000_0000_0000_0000, 0, "max quiet NaN");
        run_case(D_MAX, 64'h7ff8_0000_0000_0001, 64'hfff8_0000_0000_0002,
                 64'h7ff8_0000_0000_0000, 0, "max two NaNs");
        run_case(D_MIN, 64'h7ff0_0000_0000_0001, 64'h3ff0_0000_0000_0000,
                 64'h3ff0_0000_0000_0000, 1, "min signaling NaN");
        run_case(S_MAX, 64'hffff_ffff_3f80_0000, 64'hffff_ffff_7f80_0001,
                 64'hffff_ffff_3f80_0000, 1, "single max signaling NaN");
        run_case(S_MAX, 64'h0000_0000_3f80_0000, 64'hffff_ffff_4000_0000,
                 64'hffff_ffff_4000_0000, 0, "single bad box");
        run_case(S_MIN, 64'h0000_0000_3f80_0000, 64'h1234_5678_4000_0000,
                 64'hffff_ffff_7fc0_0000, 0, "single two bad boxes");
        report_test("minmax", e0);
    endtask

    task automatic issue_latency();
        int          e0, cycles;
        logic [3:0]  ctl [5];
        logic [63:0] a, b;
        logic [64:0] m;
        e0 = err_count;
        ctl = '{{1'b1, OP_SGNJ}, {1'b0, OP_MV}, {1'b0, OP_SGNJN}, D_MIN, S_MAX};
        for (int i = 0; i < 5; i++) begin
            random_operand(ctl[i][3], a);
            random_operand(ctl[i][3], b);
            m = model_op(ctl[i], a, b);
            send_op(ctl[i], a, b, i[1:0]);
            wait_out_valid(cycles);
            // Sign ops and MV take 3 cycles and min/max 4
            check_value(64'(cycles), (i < 3) ? 64'd3 : 64'd4, $sformatf("latency %0d", i));
            receive_result(i[1:0], m[63:0], m[64], $sformatf("latency op %0d", i));
        end
        report_test("latency", e0);
    endtask

    task automatic backpressure_order();
        int          e0, cycles;
        logic [3:0]  ctl [5];
        logic [63:0] a [5];
        logic [63:0] b [5];
        logic [64:0] m [5];
        e0 = err_count;
        ready_idle  = 1'b0;
        out_ready_i = 1'b0;
        ctl = '{{1'b1, OP_SGNJ}, D_MIN, {1'b0, OP_SGNJX}, S_MAX, {1'b1, OP_MV}};
        for (int i = 0; i < 5; i++) begin
            random_operand(ctl[i][3], a[i]);
            random_operand(ctl[i][3], b[i]);
            m[i] = model_op(ctl[i], a[i], b[i]);
        end
        for (int i = 0; i < 4; i++) begin
            send_op(ctl[i], a[i], b[i], i[1:0]);
        end
        check_value(64'(in_ready_o), 64'd0, "in_ready with four buffered");
        wait_out_valid(cycles);
        // Fifth offer stalls while the first result is held
        in_valid_i = 1'b1;
        in_ctl_i   = ctl[4];
        in_rs1_i   = a[4];
        in_rs2_i   = b[4];
        in_idx_i   = 2'd0;
        for (int n = 0; n < 3; n++) begin
            step_cycle();
            check_value(64'(in_ready_o), 64'd0, "in_ready under back-pressure");
            check_value(64'(out_valid_o), 64'd1, "out_valid held");
            check_value(out_result_o, m[0][63:0], "result held");
        end
        receive_result(2'd0, m[0][63:0], m[0][64], "ordered result 0");
        send_op(ctl[4], a[4], b[4], 2'd0);
        for (int i = 1; i < 5; i++) begin
            receive_result(i[1:0], m[i][63:0], m[i][64], $sformatf("ordered result %0d", i));
        end
        ready_idle  = 1'b1;
        out_ready_i = 1'b1;
        report_test("backpressure", e0);
    endtask

    task automatic flush_in_flight();
        int          e0, cycles;
        logic [63:0] a, b;
        e0 = err_count;
        ready_idle  = 1'b0;
        out_ready_i = 1'b0;
        send_op(D_MIN, 64'h7ff0_0000_0000_0001, 64'h3ff0_0000_0000_0000, 2'd2);
        send_op({1'b1, OP_SGNJ}, 64'h1, 64'h2, 2'd3);
        send_op({1'b0, OP_MV}, 64'h3, 64'h4, 2'd0);
        wait_out_valid(cycles);
        check_value(64'(out_except_raised_o), 64'd1, "exception before flush");
        flush_i = 1'b1;
        step_cycle();
        flush_i = 1'b0;
        check_value(64'(out_valid_o), 64'd0, "out_valid after flush");
        check_value(64'(out_except_raised_o), 64'd0, "exception flag after flush");
        check_value(64'(out_except_code_o), 64'd0, "exception code after flush");
        check_value(64'(in_ready_o), 64'd1, "in_ready after flush");
        // Dropped entries must never come out
        for (int n = 0; n < 6; n++) begin
            step_cycle();
            check_value(64'(out_valid_o), 64'd0, "no result after flush");
        end
        ready_idle  = 1'b1;
        out_ready_i = 1'b1;
        random_operand(1'b1, a);
        random_operand(1'b1, b);
        run_op({1'b1, OP_SGNJX}, a, b, 2'd1, "after flush");
        report_test("flush", e0);
    endtask

    initial begin
        rst_n_i     = 1'b0;
        flush_i     = 1'b0;
        in_valid_i  = 1'b0;
        in_ctl_i    = '0;
        in_rs1_i    = '0;
        in_rs2_i    = '0;
        in_idx_i    = '0;
        out_ready_i = 1'b1;
        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        reset_state();
        sign_ops_random();
        minmax_special();
        issue_latency();
        backpressure_order();
        flush_in_flight();
        $display("Summary: %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/fpu_pkg.sv
hw/fp_rs_entry_table.sv
hw/fp_issue_ctrl.sv
hw/fp_latency_timer.sv
hw/fpu_sgnj_minmax.sv
hw/fp_exec_cluster.sv
test/fp_exec_cluster_tb.sv
